//--- design/alu.sv
// combinational arithmetic and logic unit producing result byte with carry and zero
`timescale 1ns/100ps

module alu (
    input  cpu8_pkg::op_t                 alu_op,
    input  logic [cpu8_pkg::DATA_W-1:0]   a,
    input  logic [cpu8_pkg::DATA_W-1:0]   b,
    output cpu8_pkg::alu_out_t            res
);
    import cpu8_pkg::*;

    // one extra bit on top for carry or borrow
    logic [DATA_W:0]          sum;
    logic [DATA_W:0]          diff;

    // shift amount from the low bits of b
    logic [$clog2(DATA_W)-1:0] shamt;

    // double width so the bits pushed out stay visible
    logic [2*DATA_W-1:0]      shl_wide;

    // result byte before flag generation
    logic [DATA_W-1:0]        data;
    logic                     carry;

    always_comb begin
        sum      = {1'b0, a} + {1'b0, b};
        // top bit goes high when b > a
        diff     = {1'b0, a} - {1'b0, b};
        shamt    = b[$clog2(DATA_W)-1:0];
        shl_wide = {{DATA_W{1'b0}}, a} << shamt;
    end

    // operation select
    always_comb begin
        data  = '0;
        carry = 1'b0;
        case (alu_op)
            OP_ADD: begin
                data  = sum[DATA_W-1:0];
                carry = sum[DATA_W];
            end
            OP_SUB: begin
                data  = diff[DATA_W-1:0];
                // borrow
                carry = diff[DATA_W];
            end
            OP_AND: data = a & b;
            OP_OR:  data = a | b;
            OP_XOR: data = a ^ b;
            OP_SHL: begin
                data  = shl_wide[DATA_W-1:0];
                // last bit shifted out sits just above the byte
                // stays 0 for a zero shift amount
                carry = shl_wide[DATA_W];
            end
            // pass the immediate through
            OP_LDI: data = b;
            // nop leaves everything cleared
            default: begin
                data  = '0;
                carry = 1'b0;
            end
        endcase
    end

    // pack outputs
    always_comb begin
        res.data  = data;
        res.carry = carry;
        res.zero  = (data == '0);
    end

endmodule

//--- design/cpu8_core.sv
// top of the 8-bit execution core joining issue control with the register bank and the alu
`timescale 1ns/100ps

module cpu8_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  cpu8_pkg::instr_t    instr,
    output logic                result_valid,
    output cpu8_pkg::result_t   result
);
    import cpu8_pkg::*;

    // bank read side
    logic [REG_AW-1:0]  ra1;
    logic [REG_AW-1:0]  ra2;
    logic [DATA_W-1:0]  rd1;
    logic [DATA_W-1:0]  rd2;

    // bank write side
    logic               we;
    logic [REG_AW-1:0]  wa;
    logic [DATA_W-1:0]  wd;

    // alu side
    op_t                alu_op;
    logic [DATA_W-1:0]  a;
    logic [DATA_W-1:0]  b;
    alu_out_t           alu_res;

    // decode and result register
    issue_ctrl u_issue (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rd1          (rd1),
        .rd2          (rd2),
        .alu_res      (alu_res),
        .ra1          (ra1),
        .ra2          (ra2),
        .wa           (wa),
        .we           (we),
        .wd           (wd),
        .alu_op       (alu_op),
        .a            (a),
        .b            (b),
        .result_valid (result_valid),
        .result       (result)
    );

    // architectural registers
    reg_file u_regs (
        .clk (clk),
        .rst (rst),
        .we  (we),
        .wa  (wa),
        .ra1 (ra1),
        .ra2 (ra2),
        .wd  (wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // zero-latency datapath
    alu u_alu (
        .alu_op (alu_op),
        .a      (a),
        .b      (b),
        .res    (alu_res)
    );

endmodule

//--- design/cpu8_pkg.sv
// shared widths, opcodes and bus structs for the 8-bit execution core
package cpu8_pkg;

    // datapath width in bits
    localparam int DATA_W = 8;

    // architectural registers
    // entry 0 is hardwired to zero
    localparam int NUM_REGS = 8;

    // bits needed to address one register
    localparam int REG_AW = 3;

    // opcode encoding
    // nop must stay at zero so an idle bus decodes harmlessly
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        // arithmetic
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        // bitwise logic
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        // shift by rs2[2:0]
        OP_SHL = 3'd6,
        // load immediate into rd
        OP_LDI = 3'd7
    } op_t;

    // one instruction word as it arrives on the input bus
    // 3 + 3 + 3 + 3 + 8 = 20 bits
    typedef struct packed {
        // operation to perform
        op_t                op;
        // destination register
        logic [REG_AW-1:0]  rd;
        // first source, feeds operand a
        logic [REG_AW-1:0]  rs1;
        // second source, feeds operand b unless ldi
        logic [REG_AW-1:0]  rs2;
        // immediate byte, only used by ldi
        logic [DATA_W-1:0]  imm;
    } instr_t;

    // alu output bundle
    // 8 + 1 + 1 = 10 bits
    typedef struct packed {
        logic [DATA_W-1:0]  data;
        // carry out on add, borrow on sub, last bit out on shl
        logic               carry;
        // set when data is all zeros
        logic               zero;
    } alu_out_t;

    // registered result port
    // destination tag plus the alu bundle, 13 bits
    typedef struct packed {
        logic [REG_AW-1:0]  rd;
        alu_out_t           alu;
    } result_t;

endpackage

//--- design/issue_ctrl.sv
// instruction decode with operand steering and bank write plus the registered result port
`timescale 1ns/100ps

module issue_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  cpu8_pkg::instr_t              instr,
    input  logic [cpu8_pkg::DATA_W-1:0]   rd1,
    input  logic [cpu8_pkg::DATA_W-1:0]   rd2,
    input  cpu8_pkg::alu_out_t            alu_res,
    output logic [cpu8_pkg::REG_AW-1:0]   ra1,
    output logic [cpu8_pkg::REG_AW-1:0]   ra2,
    output logic [cpu8_pkg::REG_AW-1:0]   wa,
    output logic                          we,
    output logic [cpu8_pkg::DATA_W-1:0]   wd,
    output cpu8_pkg::op_t                 alu_op,
    output logic [cpu8_pkg::DATA_W-1:0]   a,
    output logic [cpu8_pkg::DATA_W-1:0]   b,
    output logic                          result_valid,
    output cpu8_pkg::result_t             result
);
    import cpu8_pkg::*;

    // instruction accepted this edge and it does something
    logic accept;

    always_comb begin
        accept = instr_valid && (instr.op != OP_NOP);
    end

    // source addressing straight from the instruction
    always_comb begin
        ra1 = instr.rs1;
        ra2 = instr.rs2;
    end

    // operand steering
    // ldi swaps rd2 for the immediate
    always_comb begin
        alu_op = instr.op;
        a      = rd1;
        b      = (instr.op == OP_LDI) ? instr.imm : rd2;
    end

    // bank write from the alu output
    // skip r0 here as well so the bank sees no pointless strobe
    always_comb begin
        wa = instr.rd;
        wd = alu_res.data;
        we = accept && (instr.rd != '0);
    end

    // result strobe
    // r0 targets still report and only nop is silent
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= accept;
        end
    end

    // result payload
    // held until the next accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            result.rd  <= instr.rd;
            result.alu <= alu_res;
        end
    end

    // one-cycle issue latency on the result port
    // captured payload must be fully resolved by the bank and alu
    a_result_follows: assert property (
        @(posedge clk) disable iff (rst)
        accept |=> result_valid && !$isunknown(result)
    ) else $error("issue_ctrl result port not valid and known after an accepted op");

    // input bus must be fully driven whenever it is strobed
    a_instr_known: assert property (
        @(posedge clk) disable iff (rst)
        instr_valid |-> !$isunknown(instr)
    ) else $error("issue_ctrl instruction has unknown bits while valid");

endmodule

//--- design/reg_file.sv
// register bank of eight bytes with two combinational read ports and one write port
`timescale 1ns/100ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [cpu8_pkg::REG_AW-1:0]   wa,
    input  logic [cpu8_pkg::REG_AW-1:0]   ra1,
    input  logic [cpu8_pkg::REG_AW-1:0]   ra2,
    input  logic [cpu8_pkg::DATA_W-1:0]   wd,
    output logic [cpu8_pkg::DATA_W-1:0]   rd1,
    output logic [cpu8_pkg::DATA_W-1:0]   rd2
);
    import cpu8_pkg::*;

    // writable entries only
    // entry 0 has no storage at all
    logic [DATA_W-1:0] regs [1:NUM_REGS-1];

    // write port
    // lands at the same edge that accepts the instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            // writes to address 0 fall through here and are lost
            regs[wa] <= wd;
        end
    end

    // two independent read selects
    // default covers address 0 which always reads as zero
    always_comb begin
        rd1 = '0;
        rd2 = '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            if (ra1 == REG_AW'(i)) begin
                rd1 = regs[i];
            end
            if (ra2 == REG_AW'(i)) begin
                rd2 = regs[i];
            end
        end
    end

    // no read-during-write bypass
    // a read in the write cycle still sees the old value

    // write strobe must be clean once out of reset
    // an x here would corrupt an unknown set of entries
    a_we_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(we)
    ) else $error("reg_file write enable is unknown");

endmodule

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module cpu8_tb \
    -Mdir obj_dir -o cpu8_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu8_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- sources.f
design/cpu8_pkg.sv
design/reg_file.sv
design/alu.sv
design/issue_ctrl.sv
design/cpu8_core.sv
tb/cpu8_checker.sv
tb/cpu8_tb.sv

//--- tb/cpu8_checker.sv
// result checker for the execution core holding a register model and the reference function
`timescale 1ns/100ps

module cpu8_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  cpu8_pkg::instr_t    instr,
    input  logic                result_valid,
    input  cpu8_pkg::result_t   result,
    output int                  error_count,
    output int                  check_count
);
    import cpu8_pkg::*;

    // architectural state as the core should hold it
    logic [DATA_W-1:0] model [0:NUM_REGS-1];
    // expectation waits one cycle for the registered port
    result_t expect_q [$];

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // expected result of one accepted instruction
    function automatic result_t expected_result(input instr_t ins,
                                                input logic [DATA_W-1:0] va,
                                                input logic [DATA_W-1:0] vb);
        result_t r;
        int full;
        int sh;
        r.rd = ins.rd;
        r.alu.data = '0;
        r.alu.carry = 1'b0;
        full = 0;
        sh = int'(vb[2:0]);
        case (ins.op)
            OP_ADD: begin
                full = int'(va) + int'(vb);
                // sum too large for one byte
                r.alu.carry = (full >= (1 << DATA_W));
            end
            OP_SUB: begin
                full = int'(va) - int'(vb);
                // borrow when b is larger
                r.alu.carry = (full < 0);
            end
            OP_AND: full = int'(va & vb);
            OP_OR:  full = int'(va | vb);
            OP_XOR: full = int'(va ^ vb);
            OP_SHL: begin
                full = int'(va) << sh;
                // last bit pushed out of a, none for a zero shift
                r.alu.carry = (sh != 0) ? va[DATA_W - sh] : 1'b0;
            end
            OP_LDI: full = int'(ins.imm);
            default: full = 0;
        endcase
        r.alu.data = full[DATA_W-1:0];
        r.alu.zero = (r.alu.data == '0);
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] want);
        if (got !== want) begin
            $display("Error result %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
            error_count++;
        end
    endtask

    // inputs and the result port are both settled at negedge
    always @(negedge clk) begin
        result_t exp_r;
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model[i] = '0;
            end
            expect_q.delete();
        end else begin
            // result port from the previous edge
            if (result_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    $display("result_valid went high with no instruction pending at %0t", $time);
                    error_count++;
                end else begin
                    exp_r = expect_q.pop_front();
                    check_count++;
                    compare_field("rd", 8'(result.rd), 8'(exp_r.rd));
                    compare_field("data", result.alu.data, exp_r.alu.data);
                    compare_field("carry", 8'(result.alu.carry), 8'(exp_r.alu.carry));
                    compare_field("zero", 8'(result.alu.zero), 8'(exp_r.alu.zero));
                end
            end else if (expect_q.size() != 0) begin
                $display("result_valid missing for an accepted instruction at %0t", $time);
                error_count++;
                void'(expect_q.pop_front());
            end
            // instruction that the next edge accepts
            if (instr_valid && (instr.op != OP_NOP)) begin
                exp_r = expected_result(instr, model[instr.rs1], model[instr.rs2]);
                expect_q.push_back(exp_r);
                // r0 stays zero in the model too
                if (instr.rd != '0) begin
                    model[instr.rd] = exp_r.alu.data;
                end
            end
        end
    end

endmodule

//--- tb/cpu8_tb.sv
// testbench for the 8-bit execution core with directed and random instruction streams
`timescale 1ns/100ps

module cpu8_tb;
    import cpu8_pkg::*;

    localparam int CLK_PERIOD = 100;
    // cycles per test including the two drain cycles
    localparam int LEN_RESET = 3;
    localparam int LEN_T1 = 8;
    localparam int LEN_T2 = 23;
    localparam int LEN_T3 = 42;
    localparam int LEN_T4 = 5;
    localparam int LEN_T5 = 11;
    localparam int LEN_T6 = 202;
    localparam int TIMEOUT_CYCLES = LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4
                                    + LEN_T5 + LEN_T6 + 40;

    logic clk;
    logic rst;
    logic instr_valid;
    instr_t instr;
    logic result_valid;
    result_t result;
    int error_count;
    int check_count;
    integer seed;
    int cycles;
    int err_mark;
    int tests_run;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu8_core uut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    cpu8_checker chk (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // one instruction, driven just after the edge
    task automatic send(input op_t op, input logic [REG_AW-1:0] rd,
                        input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
                        input logic [DATA_W-1:0] imm);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr = '0;
    endtask

    // arith_only keeps the op within add to shl
    task automatic send_random(input bit arith_only);
        logic [31:0] rnd;
        op_t op;
        rnd = $random(seed);
        if (arith_only) begin
            op = op_t'(3'(1 + rnd[31:24] % 6));
        end else begin
            op = op_t'(rnd[26:24]);
        end
        send(op, rnd[2:0], rnd[5:3], rnd[8:6], rnd[23:16]);
    endtask

    // drain the result port, then report this test
    task automatic end_test(input string name);
        idle_cycle();
        idle_cycle();
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, error_count - err_mark);
        err_mark = error_count;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        seed = 66;
        cycles = 0;
        err_mark = 0;
        tests_run = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet after reset, then every register reads zero
        repeat (4) idle_cycle();
        send(OP_ADD, 3'd1, 3'd2, 3'd3, 8'h00);
        send(OP_ADD, 3'd4, 3'd5, 3'd6, 8'h00);
        end_test("reset state");

        // load all writable registers and read back on both ports
        for (int k = 1; k < NUM_REGS; k++) begin
            send(OP_LDI, REG_AW'(k), 3'd0, 3'd0, 8'($random(seed)));
        end
        for (int k = 1; k < NUM_REGS; k++) begin
            send(OP_OR, 3'd0, REG_AW'(k), 3'd0, 8'h00);
            send(OP_OR, 3'd0, 3'd0, REG_AW'(k), 8'h00);
        end
        end_test("load and read ports");

        repeat (40) send_random(1'b1);
        end_test("random alu ops");

        // r0 reports the immediate but keeps reading zero
        send(OP_LDI, 3'd0, 3'd0, 3'd0, 8'ha5);
        send(OP_OR, 3'd1, 3'd0, 3'd0, 8'h00);
        send(OP_ADD, 3'd2, 3'd0, 3'd0, 8'h00);
        end_test("zero register");

        // dependent chain with nops in between
        send(OP_LDI, 3'd1, 3'd0, 3'd0, 8'h21);
        send(OP_ADD, 3'd2, 3'd1, 3'd1, 8'h00);
        send(OP_NOP, 3'd3, 3'd1, 3'd2, 8'h00);
        send(OP_ADD, 3'd3, 3'd2, 3'd1, 8'h00);
        send(OP_NOP, 3'd0, 3'd0, 3'd0, 8'h00);
        send(OP_SUB, 3'd4, 3'd1, 3'd3, 8'h00);
        send(OP_SHL, 3'd5, 3'd4, 3'd1, 8'h00);
        send(OP_AND, 3'd6, 3'd5, 3'd2, 8'h00);
        send(OP_XOR, 3'd7, 3'd6, 3'd6, 8'h00);
        end_test("back-to-back dependencies");

        // full mix with idle gaps
        repeat (200) begin
            if ($unsigned($random(seed)) % 4 == 0) begin
                idle_cycle();
            end else begin
                send_random(1'b0);
            end
        end
        end_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
